// File: src/rgbw_pkg.sv
// shared types, frame and spi event structs, mode bit positions and pwm constants
`default_nettype none

package rgbw_pkg;

    // one colour level, also used for duty values and the pwm count
    typedef logic [7:0] level_t;

    // raw mode byte as sent by the host
    typedef logic [7:0] mode_t;

    // mode byte bit positions, remaining bits ignored
    // outputs enabled
    localparam int MODE_ENABLE_BIT = 0;
    // levels scaled by intensity
    localparam int MODE_DIM_BIT = 1;
    // pins active low
    localparam int MODE_ACTIVE_LOW_BIT = 2;

    // channel order: red, green, blue, white
    localparam int NUM_CHANNELS = 4;

    // one output pin per channel
    typedef logic [NUM_CHANNELS-1:0] led_t;

    // byte position inside a frame
    typedef logic [2:0] byte_idx_t;

    // mode, intensity, red, green, blue, white
    localparam byte_idx_t FRAME_BYTES = 3'd6;

    // last count of a pwm period, period is PWM_MAX + 1 counts
    localparam level_t PWM_MAX = 8'd254;

    // clocks per pwm count
    localparam int PWM_PRESCALE = 2;

    // active colour frame
    // level[0] red ... level[3] white
    typedef struct packed {
        mode_t                         mode;
        level_t                        intensity;
        level_t [NUM_CHANNELS-1:0]     level;
    } color_frame_t;

    // receiver to frame dispenser
    // both flags are single cycle strobes
    typedef struct packed {
        logic   byte_valid;
        logic   frame_end;
        level_t data;
    } spi_event_t;

endpackage

`default_nettype wire

// File: src/spi_rx.sv
// spi mode 0 receiver: pin synchronizers, msb-first byte assembly, frame end strobe
`default_nettype none

module spi_rx (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sck,
    input  logic                  cs_n,
    input  logic                  mosi,
    output rgbw_pkg::spi_event_t  evt
);
    import rgbw_pkg::*;

    // [1:0] two-flop sync, [2] previous value for edge detect
    logic [2:0] sck_sr;
    logic [2:0] cs_sr;
    // mosi only needs the sync stages, kept aligned with sck_sr[1]
    logic [1:0] mosi_sr;

    logic       sck_rise;
    logic       cs_rise;
    logic       cs_active;

    // bits received in the current byte
    logic [2:0] bit_cnt;
    level_t     shift_q;
    level_t     byte_next;

    logic       byte_valid_q;
    logic       frame_end_q;
    level_t     data_q;

    // sck idles low, cs_n idles high in mode 0
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sck_sr  <= 3'b000;
            cs_sr   <= 3'b111;
            mosi_sr <= 2'b00;
        end
        else
        begin
            sck_sr  <= {sck_sr[1:0], sck};
            cs_sr   <= {cs_sr[1:0], cs_n};
            mosi_sr <= {mosi_sr[0], mosi};
        end
    end

    assign sck_rise  = sck_sr[1] & ~sck_sr[2];
    assign cs_rise   = cs_sr[1] & ~cs_sr[2];
    assign cs_active = ~cs_sr[1];

    // byte as it stands once the current bit is shifted in
    assign byte_next = {shift_q[6:0], mosi_sr[1]};

    // bit counter, cleared while deselected so a cut byte is lost
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            bit_cnt <= 3'd0;
        else if (!cs_active)
            bit_cnt <= 3'd0;
        else if (sck_rise)
            bit_cnt <= bit_cnt + 3'd1;
    end

    // sample on sck rise, msb first
    always_ff @(posedge clk)
    begin
        if (cs_active && sck_rise)
            shift_q <= byte_next;
    end

    // strobes land 3 clk after the pin edge
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            byte_valid_q <= 1'b0;
            frame_end_q  <= 1'b0;
        end
        else
        begin
            // eighth bit completes the byte
            byte_valid_q <= cs_active & sck_rise & (bit_cnt == 3'd7);
            frame_end_q  <= cs_rise;
        end
    end

    // completed byte held until the next one
    always_ff @(posedge clk)
    begin
        if (cs_active && sck_rise && bit_cnt == 3'd7)
            data_q <= byte_next;
    end

    assign evt.byte_valid = byte_valid_q;
    assign evt.frame_end  = frame_end_q;
    assign evt.data       = data_q;

endmodule

`default_nettype wire

// File: src/frame_dispenser.sv
// frame dispenser: byte counting into shadow registers, commit of complete frames
`default_nettype none

module frame_dispenser (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rgbw_pkg::spi_event_t    evt,
    output rgbw_pkg::color_frame_t  frame
);
    import rgbw_pkg::*;

    // bytes seen since the last frame end
    byte_idx_t    byte_cnt;
    // set once a byte arrives past FRAME_BYTES
    logic         overflow;
    logic         frame_full;
    color_frame_t shadow;

    assign frame_full = (byte_cnt == FRAME_BYTES);

    // counter, overflow mark and the active frame
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            byte_cnt <= '0;
            overflow <= 1'b0;
            frame    <= '0;
        end
        else if (evt.frame_end)
        begin
            // short, long or overflowed frames are dropped
            if (frame_full && !overflow)
                frame <= shadow;
            // next frame starts from scratch either way
            byte_cnt <= '0;
            overflow <= 1'b0;
        end
        else if (evt.byte_valid)
        begin
            // saturate, extra bytes only poison the frame
            if (frame_full)
                overflow <= 1'b1;
            else
                byte_cnt <= byte_cnt + 3'd1;
        end
    end

    // shadow fields, byte order mode, intensity, then levels
    always_ff @(posedge clk)
    begin
        if (evt.byte_valid && !evt.frame_end && !frame_full)
        begin
            case (byte_cnt)
                3'd0:
                    shadow.mode <= evt.data;
                3'd1:
                    shadow.intensity <= evt.data;
                default:
                    // levels start at byte 2
                    shadow.level[byte_cnt - 3'd2] <= evt.data;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/pwm_timebase.sv
// pwm time base: clock prescaler, 8-bit period counter and period start strobe
`default_nettype none

module pwm_timebase #(
    parameter int PRESCALE = rgbw_pkg::PWM_PRESCALE
) (
    input  logic              clk,
    input  logic              arst_n,
    output rgbw_pkg::level_t  count,
    output logic              period_start
);
    import rgbw_pkg::*;

    // at least one bit even when PRESCALE is 1
    localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [PW-1:0] presc;
    logic          tick;

    // last clock of the current count
    assign tick = (presc == PW'(PRESCALE - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            presc <= '0;
            count <= '0;
        end
        else
        begin
            presc <= tick ? '0 : presc + 1'b1;
            if (tick)
                // wraps after PWM_MAX, 255 counts per period
                count <= (count == PWM_MAX) ? '0 : count + 8'd1;
        end
    end

    // first clock of count 0
    assign period_start = (count == '0) && (presc == '0);

endmodule

`default_nettype wire

// File: src/pwm_channel.sv
// pwm channel: effective duty with optional dimming, period latch and compare
`default_nettype none

module pwm_channel (
    input  logic              clk,
    input  logic              arst_n,
    input  rgbw_pkg::level_t  level,
    input  rgbw_pkg::level_t  intensity,
    input  logic              dim,
    input  rgbw_pkg::level_t  count,
    input  logic              period_start,
    output logic              pwm
);
    import rgbw_pkg::*;

    logic [15:0] product;
    level_t      duty_eff;
    // duty in force for the running period
    level_t      duty_q;
    level_t      duty_now;

    // level * intensity / 256 when dimming
    assign product  = level * intensity;
    assign duty_eff = dim ? product[15:8] : level;

    // new duty already applies on the period start clock itself
    assign duty_now = period_start ? duty_eff : duty_q;

    // only sampled on a period boundary so no period gets cut
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            duty_q <= '0;
        else if (period_start)
            duty_q <= duty_eff;
    end

    // high while count below duty
    // duty 255 stays high all period since count stops at PWM_MAX
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            pwm <= 1'b0;
        else
            pwm <= (count < duty_now);
    end

endmodule

`default_nettype wire

// File: src/led_driver.sv
// led output stage: enable gating and polarity select in one output register
`default_nettype none

module led_driver (
    input  logic             clk,
    input  logic             arst_n,
    input  rgbw_pkg::led_t   pwm,
    input  rgbw_pkg::mode_t  mode,
    output rgbw_pkg::led_t   led
);
    import rgbw_pkg::*;

    led_t gated;
    led_t led_next;

    // all channels off when disabled
    assign gated = pwm & {NUM_CHANNELS{mode[MODE_ENABLE_BIT]}};

    // active low pins idle high
    assign led_next = mode[MODE_ACTIVE_LOW_BIT] ? ~gated : gated;

    // mode taken straight from the active frame
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            led <= '0;
        else
            led <= led_next;
    end

endmodule

`default_nettype wire

// File: src/rgbw_controller.sv
// rgbw dimmer top: spi receiver, frame dispenser, time base, pwm channels, led driver
`default_nettype none

module rgbw_controller (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            sck,
    input  logic            cs_n,
    input  logic            mosi,
    output rgbw_pkg::led_t  led
);
    import rgbw_pkg::*;

    spi_event_t   evt;
    // committed colour frame
    color_frame_t frame;
    level_t       count;
    logic         period_start;
    // raw channel outputs, index = channel
    led_t         pwm_bits;

    // spi pins to byte and frame strobes
    spi_rx u_spi_rx (
        .clk    (clk),
        .arst_n (arst_n),
        .sck    (sck),
        .cs_n   (cs_n),
        .mosi   (mosi),
        .evt    (evt)
    );

    // bytes to active frame
    frame_dispenser u_frame_dispenser (
        .clk    (clk),
        .arst_n (arst_n),
        .evt    (evt),
        .frame  (frame)
    );

    // shared count for all channels
    pwm_timebase #(
        .PRESCALE (PWM_PRESCALE)
    ) u_pwm_timebase (
        .clk          (clk),
        .arst_n       (arst_n),
        .count        (count),
        .period_start (period_start)
    );

    // red, green, blue, white
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++)
    begin : g_channel
        pwm_channel u_pwm_channel (
            .clk          (clk),
            .arst_n       (arst_n),
            .level        (frame.level[ch]),
            .intensity    (frame.intensity),
            .dim          (frame.mode[MODE_DIM_BIT]),
            .count        (count),
            .period_start (period_start),
            .pwm          (pwm_bits[ch])
        );
    end

    // enable and polarity
    led_driver u_led_driver (
        .clk    (clk),
        .arst_n (arst_n),
        .pwm    (pwm_bits),
        .mode   (frame.mode),
        .led    (led)
    );

endmodule

`default_nettype wire

// File: sim/rgbw_tb.sv
// rgbw dimmer testbench: spi host model, duty measurement, frame checks and timeout
`default_nettype none

module rgbw_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rgbw_pkg::*;

    // clk per sck phase
    localparam int PHASE_CLKS = 4;
    // one full pwm period in clk
    localparam int WINDOW = 255 * PWM_PRESCALE;
    // worst case frame, 7 bytes plus cs setup and gap
    localparam int FRAME_CLKS = 7 * 8 * 2 * PHASE_CLKS + 4 * PHASE_CLKS;
    // measurement windows in the run
    localparam int NUM_CHECKS = 13;
    localparam int TIMEOUT_CYCLES = NUM_CHECKS * (2 * FRAME_CLKS + 3 * WINDOW) + 2000;

    logic   clk;
    logic   arst_n;
    logic   sck;
    logic   cs_n;
    logic   mosi;
    led_t   led;

    // bytes of the next frame, one spare for the long frame
    level_t tx_buf [0:6];
    // last committed frame as the host sees it
    mode_t  exp_mode;
    level_t exp_int;
    level_t exp_lvl [NUM_CHANNELS];
    int     hi_cnt [NUM_CHANNELS];
    int     cycle_cnt;

    rgbw_controller dut (
        .clk    (clk),
        .arst_n (arst_n),
        .sck    (sck),
        .cs_n   (cs_n),
        .mosi   (mosi),
        .led    (led)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    initial
    begin
        cycle_cnt = 0;
        forever
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt >= TIMEOUT_CYCLES)
            begin
                $display("timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
                $display("Simulation failed");
                $fatal(1, "run stopped by timeout");
            end
        end
    end

    task automatic wait_clks(input int n);
        repeat (n) @(negedge clk);
    endtask

    // mode 0, msb first, data set while sck low
    task automatic send_byte(input level_t b);
        for (int i = 7; i >= 0; i--)
        begin
            mosi = b[i];
            wait_clks(PHASE_CLKS);
            sck = 1'b1;
            wait_clks(PHASE_CLKS);
            sck = 1'b0;
        end
    endtask

    task automatic send_frame(input int n);
        cs_n = 1'b0;
        wait_clks(PHASE_CLKS);
        for (int i = 0; i < n; i++)
            send_byte(tx_buf[i]);
        wait_clks(PHASE_CLKS);
        cs_n = 1'b1;
        // frame_end lands 3 clk later, commit 1 clk after that
        wait_clks(2 * PHASE_CLKS);
    endtask

    task automatic load_frame(input mode_t m, input level_t inten, input level_t r,
                              input level_t g, input level_t b, input level_t w);
        tx_buf[0] = m;
        tx_buf[1] = inten;
        tx_buf[2] = r;
        tx_buf[3] = g;
        tx_buf[4] = b;
        tx_buf[5] = w;
        tx_buf[6] = 8'($urandom);
    endtask

    // host side copy of a frame that should be committed
    task automatic commit_model();
        exp_mode = tx_buf[0];
        exp_int  = tx_buf[1];
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            exp_lvl[ch] = tx_buf[2 + ch];
    endtask

    // high cycles per window from the mode, intensity and level rules
    function automatic int expected_count(input int ch);
        int duty;
        int on_cnt;
        if (exp_mode[MODE_DIM_BIT])
            duty = (int'(exp_lvl[ch]) * int'(exp_int)) >> 8;
        else
            duty = int'(exp_lvl[ch]);
        on_cnt = exp_mode[MODE_ENABLE_BIT] ? duty * PWM_PRESCALE : 0;
        return exp_mode[MODE_ACTIVE_LOW_BIT] ? WINDOW - on_cnt : on_cnt;
    endfunction

    // two periods to settle, then one full period counted
    task automatic check_window(input string name);
        int exp_cnt;
        wait_clks(2 * WINDOW);
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            hi_cnt[ch] = 0;
        repeat (WINDOW)
        begin
            @(negedge clk);
            for (int ch = 0; ch < NUM_CHANNELS; ch++)
                if (led[ch])
                    hi_cnt[ch] = hi_cnt[ch] + 1;
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
        begin
            exp_cnt = expected_count(ch);
            assert (hi_cnt[ch] == exp_cnt)
            else
            begin
                $display("[FAIL] %s ch%0d: expected %0d, actual %0d",
                         name, ch, exp_cnt, hi_cnt[ch]);
                $display("Simulation failed");
                $fatal(1, "high count mismatch");
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'hd2dc0358));
        arst_n   = 1'b0;
        sck      = 1'b0;
        cs_n     = 1'b1;
        mosi     = 1'b0;
        exp_mode = '0;
        exp_int  = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            exp_lvl[ch] = '0;
        wait_clks(8);
        arst_n = 1'b1;

        // nothing committed yet
        check_window("reset_idle");

        // direct mode, first frame hits both level extremes
        load_frame(8'h01, 8'($urandom), 8'h00, 8'hff, 8'($urandom), 8'($urandom));
        send_frame(FRAME_BYTES);
        commit_model();
        check_window("direct_extremes");
        for (int t = 0; t < 2; t++)
        begin
            load_frame(8'h01, 8'($urandom), 8'($urandom), 8'($urandom),
                       8'($urandom), 8'($urandom));
            send_frame(FRAME_BYTES);
            commit_model();
            check_window("direct_random");
        end

        // dimmed by intensity
        for (int t = 0; t < 2; t++)
        begin
            load_frame(8'h03, 8'($urandom), 8'($urandom), 8'($urandom),
                       8'($urandom), 8'($urandom));
            send_frame(FRAME_BYTES);
            commit_model();
            check_window("dimmed_random");
        end

        // polarity and enable combinations
        load_frame(8'h05, 8'($urandom), 8'($urandom), 8'($urandom),
                   8'($urandom), 8'($urandom));
        send_frame(FRAME_BYTES);
        commit_model();
        check_window("active_low");
        load_frame(8'h04, 8'($urandom), 8'($urandom), 8'($urandom),
                   8'($urandom), 8'($urandom));
        send_frame(FRAME_BYTES);
        commit_model();
        check_window("disabled_active_low");
        load_frame(8'h00, 8'($urandom), 8'($urandom), 8'($urandom),
                   8'($urandom), 8'($urandom));
        send_frame(FRAME_BYTES);
        commit_model();
        check_window("disabled");

        // reference frame for the bad length cases
        load_frame(8'h01, 8'($urandom), 8'($urandom), 8'($urandom),
                   8'($urandom), 8'($urandom));
        send_frame(FRAME_BYTES);
        commit_model();
        check_window("reference");
        // complemented levels so a wrong commit shows up
        load_frame(8'h01, ~exp_int, ~exp_lvl[0], ~exp_lvl[1], ~exp_lvl[2], ~exp_lvl[3]);
        send_frame(5);
        check_window("short_frame");
        load_frame(8'h01, ~exp_int, ~exp_lvl[0], ~exp_lvl[1], ~exp_lvl[2], ~exp_lvl[3]);
        send_frame(7);
        check_window("long_frame");

        // only the second of two frames should survive
        load_frame(8'h01, 8'($urandom), 8'($urandom), 8'($urandom),
                   8'($urandom), 8'($urandom));
        send_frame(FRAME_BYTES);
        load_frame(8'h01, 8'($urandom), 8'($urandom), 8'($urandom),
                   8'($urandom), 8'($urandom));
        send_frame(FRAME_BYTES);
        commit_model();
        check_window("back_to_back");

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
src/rgbw_pkg.sv
src/spi_rx.sv
src/frame_dispenser.sv
src/pwm_timebase.sv
src/pwm_channel.sv
src/led_driver.sv
src/rgbw_controller.sv
sim/rgbw_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rgbw dimmer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module rgbw_tb -f src.f

out=$(./obj_dir/Vrgbw_tb) || { echo "$out"; exit 1; }
echo "$out"

# pass only when the testbench reported it
echo "$out" | grep -qx "Simulation passed"
